// File: flist.f
+incdir+sim
src/robPkg.sv
src/dispatchIf.sv
src/commitIf.sv
src/sqnDispatch.sv
src/reorderBuffer.sv
src/commitStage.sv
src/robTop.sv
sim/robTb.sv

// File: sim/robTbModel.svh
`ifndef ROB_TB_MODEL_SVH
`define ROB_TB_MODEL_SVH

// one accepted instruction, kept in program order
typedef struct packed {
    logic [robPkg::SQN_W-1:0] sqn;
    logic [robPkg::NAME_W-1:0] name;
    logic [robPkg::TAG_W-1:0] tag;
    logic done;
    logic [31:0] enterEdge;
} modelOp;

modelOp inflight [$];
int modelCredits = robPkg::ROB_LENGTH;
// flushed entries come back to the credit counter two edges after the decision
int refundNext = 0;
int refundDue = 0;
logic [robPkg::SQN_W-1:0] modelSqn = '0;
logic [robPkg::TAG_W-1:0] expMap [robPkg::NUM_REGS];

// a committed lane has to be the oldest instruction in flight
task automatic retireLane(input logic [robPkg::NAME_W-1:0] name,
                          input logic [robPkg::TAG_W-1:0] tag);
    modelOp op;
    assert (inflight.size() > 0) else begin
        $display("%0t: commit seen with no instruction in flight", $time);
        errors++;
    end
    if (inflight.size() > 0) begin
        op = inflight.pop_front();
        compareValue("comName", op.name, name);
        compareValue("comTag", op.tag, tag);
        expMap[op.name] = op.tag;
        modelCredits++;
    end
endtask

task automatic acceptOp(input logic [robPkg::NAME_W-1:0] name,
                        input logic [robPkg::TAG_W-1:0] tag, input int enterEdge);
    modelOp op;
    op.sqn = modelSqn;
    op.name = name;
    op.tag = tag;
    op.done = 1'b0;
    op.enterEdge = enterEdge;
    inflight.push_back(op);
    modelSqn++;
    modelCredits--;
endtask

// youngest instructions sit at the back of the queue
task automatic flushYounger(input logic [robPkg::SQN_W-1:0] sqn);
    modelOp op;
    logic [robPkg::SQN_W-1:0] diff;
    bit reachedOlder;
    reachedOlder = 1'b0;
    while (!reachedOlder && inflight.size() > 0) begin
        op = inflight[$];
        diff = op.sqn - sqn;
        if ($signed(diff) > 0) begin
            op = inflight.pop_back();
            refundNext++;
        end else begin
            reachedOlder = 1'b1;
        end
    end
    modelSqn = sqn + 1'b1;
endtask

`endif

// File: sim/robTb.sv
`timescale 1ns/1ns

module robTb;

    localparam int RESET_LEN = 8;
    localparam int CREDIT_LEN = 200;
    localparam int ORDER_LEN = 200;
    localparam int FLUSH_LEN = 300;
    localparam int MAP_LEN = 200;
    // drain allowance per test
    localparam int DRAIN_LEN = 64;
    localparam int NUM_TESTS = 5;
    localparam int TIMEOUT = RESET_LEN + CREDIT_LEN + ORDER_LEN + FLUSH_LEN + MAP_LEN
                             + NUM_TESTS * DRAIN_LEN;

    logic clk;
    logic rst;
    logic [robPkg::WIDTH-1:0] dispValid;
    logic [robPkg::NAME_W-1:0] dispName0;
    logic [robPkg::TAG_W-1:0] dispTag0;
    logic [robPkg::NAME_W-1:0] dispName1;
    logic [robPkg::TAG_W-1:0] dispTag1;
    logic [robPkg::WIDTH-1:0] dispAccept;
    logic [robPkg::CNT_W-1:0] dispCredits;
    logic cplValid;
    logic [robPkg::SQN_W-1:0] cplSqn;
    logic flushValid;
    logic [robPkg::SQN_W-1:0] flushSqn;
    logic [robPkg::WIDTH-1:0] comValid;
    logic [robPkg::NAME_W-1:0] comName0;
    logic [robPkg::TAG_W-1:0] comTag0;
    logic [robPkg::NAME_W-1:0] comName1;
    logic [robPkg::TAG_W-1:0] comTag1;
    logic [robPkg::NAME_W-1:0] mapName;
    logic [robPkg::TAG_W-1:0] mapTag;

    integer seed = 32'he921;
    int errors = 0;
    int checks = 0;
    int testsFailed = 0;
    int edgeNo = 0;

    robTop u_dut (.*);

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        assert (expected === actual) else begin
            $display("MISMATCH at %0t: %s expected %0d, actual %0d", $time, name, expected,
                     actual);
            errors++;
        end
    endtask

    `include "robTbModel.svh"

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // drive on the rising edge, check and advance the model on the falling edge
    task automatic runCycle(input int dispPct, input int cplPct, input int flushPct,
                            input int nameMax);
        modelOp op;
        int idx;
        bit busy;
        logic [robPkg::WIDTH-1:0] expAccept;
        @(posedge clk);
        edgeNo++;
        if (edgeNo > TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Testbench failed");
            $finish;
        end
        dispValid <= ({$random(seed)} % 100 < dispPct) ? $random(seed) : '0;
        dispName0 <= {$random(seed)} % nameMax;
        dispTag0 <= $random(seed);
        dispName1 <= {$random(seed)} % nameMax;
        dispTag1 <= $random(seed);
        mapName <= {$random(seed)} % nameMax;
        flushValid <= 1'b0;
        cplValid <= 1'b0;
        busy = 1'b0;
        if (inflight.size() > 0 && {$random(seed)} % 100 < flushPct) begin
            op = inflight[{$random(seed)} % inflight.size()];
            // not completed, so it cannot have retired yet
            if (!op.done && op.enterEdge <= edgeNo) begin
                flushValid <= 1'b1;
                flushSqn <= op.sqn;
                busy = 1'b1;
            end
        end
        if (!busy && inflight.size() > 0 && {$random(seed)} % 100 < cplPct) begin
            idx = {$random(seed)} % inflight.size();
            for (int i = 0; i < inflight.size() && !busy; i++) begin
                op = inflight[(idx + i) % inflight.size()];
                if (!op.done && op.enterEdge <= edgeNo) begin
                    op.done = 1'b1;
                    inflight[(idx + i) % inflight.size()] = op;
                    cplValid <= 1'b1;
                    cplSqn <= op.sqn;
                    busy = 1'b1;
                end
            end
        end

        @(negedge clk);
        modelCredits += refundDue;
        refundDue = refundNext;
        refundNext = 0;
        assert (comValid != 2'b10) else begin
            $display("%0t: lane 1 committed without lane 0", $time);
            errors++;
        end
        if (comValid[0]) retireLane(comName0, comTag0);
        if (comValid[1]) retireLane(comName1, comTag1);
        compareValue("dispCredits", modelCredits, dispCredits);
        compareValue("mapTag", expMap[mapName], mapTag);
        expAccept[0] = !flushValid && dispValid[0] && modelCredits >= 1;
        expAccept[1] = expAccept[0] && dispValid[1] && modelCredits >= 2;
        compareValue("dispAccept", expAccept, dispAccept);
        if (expAccept[0]) acceptOp(dispName0, dispTag0, edgeNo + 2);
        if (expAccept[1]) acceptOp(dispName1, dispTag1, edgeNo + 2);
        if (flushValid) flushYounger(flushSqn);
    endtask

    task automatic runTest(input int num, input string title, input int len,
                           input int dispPct, input int cplPct, input int flushPct,
                           input int nameMax);
        int startErrors;
        startErrors = errors;
        repeat (len) begin
            runCycle(dispPct, cplPct, flushPct, nameMax);
            // nothing may commit straight out of reset
            if (num == 1) compareValue("comValid", 0, comValid);
        end
        // drain: no new work, complete all that is still in flight
        while (inflight.size() > 0 || refundNext != 0 || refundDue != 0) begin
            runCycle(0, 100, 0, nameMax);
        end
        compareValue("dispCredits", robPkg::ROB_LENGTH, dispCredits);
        if (errors != startErrors) testsFailed++;
        $display("test %0d %s: %s, %0d errors", num, title,
                 (errors == startErrors) ? "ok" : "FAILED", errors - startErrors);
    endtask

    initial begin
        rst = 1'b1;
        dispValid = '0;
        dispName0 = '0;
        dispTag0 = '0;
        dispName1 = '0;
        dispTag1 = '0;
        cplValid = 1'b0;
        cplSqn = '0;
        flushValid = 1'b0;
        flushSqn = '0;
        mapName = '0;
        for (int n = 0; n < robPkg::NUM_REGS; n++) begin
            expMap[n] = n;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        runTest(1, "reset state", RESET_LEN, 0, 0, 0, robPkg::NUM_REGS);
        runTest(2, "credit accounting", CREDIT_LEN, 90, 20, 0, robPkg::NUM_REGS);
        runTest(3, "in-order retirement", ORDER_LEN, 60, 80, 0, robPkg::NUM_REGS);
        runTest(4, "flush", FLUSH_LEN, 70, 60, 10, robPkg::NUM_REGS);
        // few names so both lanes often write the same register
        runTest(5, "committed map", MAP_LEN, 70, 70, 3, 4);

        $display("tests %0d, failed %0d, checks %0d, errors %0d", NUM_TESTS, testsFailed,
                 checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: src/commitIf.sv
`timescale 1ns/1ns

interface commitIf;

    // no back-pressure, the sink takes whatever retires
    robPkg::retireKind kind;
    logic [robPkg::NAME_W-1:0] name [robPkg::WIDTH];
    logic [robPkg::TAG_W-1:0] tag [robPkg::WIDTH];
    logic [robPkg::SQN_W-1:0] sqn [robPkg::WIDTH];

    modport source (
        output kind,
        output name,
        output tag,
        output sqn
    );

    modport sink (
        input kind,
        input name,
        input tag,
        input sqn
    );

endinterface

// File: src/commitStage.sv
`timescale 1ns/1ns

module commitStage (
    input  logic                       clk,
    input  logic                       rst,
    commitIf.sink                      com,
    output logic [robPkg::WIDTH-1:0]   comValid,
    output logic [robPkg::NAME_W-1:0]  comName0,
    output logic [robPkg::TAG_W-1:0]   comTag0,
    output logic [robPkg::NAME_W-1:0]  comName1,
    output logic [robPkg::TAG_W-1:0]   comTag1,
    input  logic [robPkg::NAME_W-1:0]  mapName,
    output logic [robPkg::TAG_W-1:0]   mapTag
);

    // committed register map
    logic [robPkg::TAG_W-1:0] map [robPkg::NUM_REGS];
    logic [robPkg::WIDTH-1:0] laneValid;

    always_comb begin
        case (com.kind)
            robPkg::RETIRE_ONE: laneValid = 2'b01;
            robPkg::RETIRE_TWO: laneValid = 2'b11;
            default: laneValid = 2'b00;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            comValid <= '0;
            // identity mapping out of reset
            for (int n = 0; n < robPkg::NUM_REGS; n++) begin
                map[n] <= n[robPkg::TAG_W-1:0];
            end
        end else begin
            comValid <= laneValid;
            // lane 1 is the younger one, written last so it wins on a shared name
            if (laneValid[0]) begin
                map[com.name[0]] <= com.tag[0];
            end
            if (laneValid[1]) begin
                map[com.name[1]] <= com.tag[1];
            end
        end
    end

    always_ff @(posedge clk) begin
        comName0 <= com.name[0];
        comTag0 <= com.tag[0];
        comName1 <= com.name[1];
        comTag1 <= com.tag[1];
    end

    assign mapTag = map[mapName];

endmodule

// File: src/dispatchIf.sv
`timescale 1ns/1ns

interface dispatchIf;

    // numbered instructions, lane 1 only valid with lane 0
    logic [robPkg::WIDTH-1:0] opValid;
    logic [robPkg::SQN_W-1:0] opSqn [robPkg::WIDTH];
    logic [robPkg::TAG_W-1:0] opTag [robPkg::WIDTH];
    logic [robPkg::NAME_W-1:0] opName [robPkg::WIDTH];

    // freed entries, added to the credits on the next edge
    logic [robPkg::CNT_W-1:0] creditReturn;

    modport source (
        output opValid,
        output opSqn,
        output opTag,
        output opName,
        input  creditReturn
    );

    modport sink (
        input  opValid,
        input  opSqn,
        input  opTag,
        input  opName,
        output creditReturn
    );

endinterface

// File: src/reorderBuffer.sv
`timescale 1ns/1ns

module reorderBuffer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cplValid,
    input  logic [robPkg::SQN_W-1:0]  cplSqn,
    input  logic                      flushValid,
    input  logic [robPkg::SQN_W-1:0]  flushSqn,
    dispatchIf.sink                   disp,
    commitIf.source                   com
);

    // circular buffer, slot = low bits of the sequence number
    robPkg::robEntry entries [robPkg::ROB_LENGTH];
    logic [robPkg::SQN_W-1:0] head;

    logic [robPkg::IDX_W-1:0] headIdx;
    logic [robPkg::IDX_W-1:0] nextIdx;
    robPkg::robEntry headEntry;
    robPkg::robEntry nextEntry;

    robPkg::retireKind kind;
    logic [robPkg::CNT_W-1:0] retireCnt;
    logic [robPkg::CNT_W-1:0] flushCnt;
    logic [robPkg::ROB_LENGTH-1:0] youngMask;

    logic [robPkg::SQN_W-1:0] cplOffset;
    logic cplHit;

    assign headIdx = head[robPkg::IDX_W-1:0];
    assign nextIdx = headIdx + 1'b1;
    assign headEntry = entries[headIdx];
    assign nextEntry = entries[nextIdx];

    // in-order retirement from the head, held off during a flush
    always_comb begin
        kind = robPkg::RETIRE_NONE;
        retireCnt = '0;
        if (!flushValid && headEntry.valid && headEntry.done) begin
            if (nextEntry.valid && nextEntry.done) begin
                kind = robPkg::RETIRE_TWO;
                retireCnt = 2;
            end else begin
                kind = robPkg::RETIRE_ONE;
                retireCnt = 1;
            end
        end
    end

    // entries younger than the flush point
    always_comb begin
        logic [robPkg::IDX_W-1:0] offset;
        logic [robPkg::SQN_W-1:0] slotSqn;
        youngMask = '0;
        flushCnt = '0;
        for (int i = 0; i < robPkg::ROB_LENGTH; i++) begin
            // rebuild the full sequence number from the slot position
            offset = i[robPkg::IDX_W-1:0] - headIdx;
            slotSqn = head + offset;
            if (flushValid && entries[i].valid && $signed(slotSqn - flushSqn) > 0) begin
                youngMask[i] = 1'b1;
                flushCnt = flushCnt + 1'b1;
            end
        end
    end

    // completions outside the live window are dropped
    assign cplOffset = cplSqn - head;
    assign cplHit = cplValid && (cplOffset < robPkg::ROB_LENGTH)
                    && entries[cplSqn[robPkg::IDX_W-1:0]].valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < robPkg::ROB_LENGTH; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].done <= 1'b0;
            end
            head <= '0;
            disp.creditReturn <= '0;
            com.kind <= robPkg::RETIRE_NONE;
        end else begin
            if (cplHit) begin
                entries[cplSqn[robPkg::IDX_W-1:0]].done <= 1'b1;
            end

            // pending lanes are younger than any flush point
            for (int l = 0; l < robPkg::WIDTH; l++) begin
                if (disp.opValid[l] && !flushValid) begin
                    entries[disp.opSqn[l][robPkg::IDX_W-1:0]].valid <= 1'b1;
                    entries[disp.opSqn[l][robPkg::IDX_W-1:0]].done <= 1'b0;
                    entries[disp.opSqn[l][robPkg::IDX_W-1:0]].tag <= disp.opTag[l];
                    entries[disp.opSqn[l][robPkg::IDX_W-1:0]].name <= disp.opName[l];
                end
            end

            if (kind != robPkg::RETIRE_NONE) begin
                entries[headIdx].valid <= 1'b0;
                entries[headIdx].done <= 1'b0;
            end
            if (kind == robPkg::RETIRE_TWO) begin
                entries[nextIdx].valid <= 1'b0;
                entries[nextIdx].done <= 1'b0;
            end
            head <= head + retireCnt;

            for (int i = 0; i < robPkg::ROB_LENGTH; i++) begin
                if (youngMask[i]) begin
                    entries[i].valid <= 1'b0;
                    entries[i].done <= 1'b0;
                end
            end

            // retired and flushed slots both give credits back
            disp.creditReturn <= retireCnt + flushCnt;
            com.kind <= kind;
        end
    end

    // retiring lanes, qualified by kind
    always_ff @(posedge clk) begin
        com.name[0] <= headEntry.name;
        com.tag[0] <= headEntry.tag;
        com.sqn[0] <= head;
        com.name[1] <= nextEntry.name;
        com.tag[1] <= nextEntry.tag;
        com.sqn[1] <= head + 1'b1;
    end

endmodule

// File: src/robPkg.sv
package robPkg;

    // buffer depth, doubles as the initial credit count
    localparam int ROB_LENGTH = 16;
    // dispatch and retirement lanes
    localparam int WIDTH = 2;

    localparam int SQN_W = 6;
    localparam int TAG_W = 6;
    localparam int NAME_W = 5;

    // slot index inside the buffer
    localparam int IDX_W = 4;
    // credit counts span 0 to ROB_LENGTH
    localparam int CNT_W = 5;
    localparam logic [CNT_W-1:0] CREDIT_MAX = CNT_W'(ROB_LENGTH);

    // architectural register file size
    localparam int NUM_REGS = 1 << NAME_W;

    typedef struct packed {
        logic valid;
        logic done;
        logic [TAG_W-1:0] tag;
        logic [NAME_W-1:0] name;
    } robEntry;

    // per-cycle retirement decision
    typedef enum logic [1:0] {
        RETIRE_NONE,
        RETIRE_ONE,
        RETIRE_TWO
    } retireKind;

    // sequence counter state around a flush
    typedef enum logic {
        FLUSH_IDLE,
        FLUSH_RECOVER
    } flushPhase;

endpackage

// File: src/robTop.sv
`timescale 1ns/1ns

module robTop (
    input  logic                       clk,
    input  logic                       rst,

    // dispatch
    input  logic [robPkg::WIDTH-1:0]   dispValid,
    input  logic [robPkg::NAME_W-1:0]  dispName0,
    input  logic [robPkg::TAG_W-1:0]   dispTag0,
    input  logic [robPkg::NAME_W-1:0]  dispName1,
    input  logic [robPkg::TAG_W-1:0]   dispTag1,
    output logic [robPkg::WIDTH-1:0]   dispAccept,
    output logic [robPkg::CNT_W-1:0]   dispCredits,

    // completion and flush
    input  logic                       cplValid,
    input  logic [robPkg::SQN_W-1:0]   cplSqn,
    input  logic                       flushValid,
    input  logic [robPkg::SQN_W-1:0]   flushSqn,

    // commit
    output logic [robPkg::WIDTH-1:0]   comValid,
    output logic [robPkg::NAME_W-1:0]  comName0,
    output logic [robPkg::TAG_W-1:0]   comTag0,
    output logic [robPkg::NAME_W-1:0]  comName1,
    output logic [robPkg::TAG_W-1:0]   comTag1,

    // committed map read
    input  logic [robPkg::NAME_W-1:0]  mapName,
    output logic [robPkg::TAG_W-1:0]   mapTag
);

    dispatchIf dispBus ();
    commitIf comBus ();

    sqnDispatch uDispatch (
        .clk         (clk),
        .rst         (rst),
        .dispValid   (dispValid),
        .dispName0   (dispName0),
        .dispTag0    (dispTag0),
        .dispName1   (dispName1),
        .dispTag1    (dispTag1),
        .flushValid  (flushValid),
        .flushSqn    (flushSqn),
        .dispAccept  (dispAccept),
        .dispCredits (dispCredits),
        .rob         (dispBus.source)
    );

    reorderBuffer uRob (
        .clk        (clk),
        .rst        (rst),
        .cplValid   (cplValid),
        .cplSqn     (cplSqn),
        .flushValid (flushValid),
        .flushSqn   (flushSqn),
        .disp       (dispBus.sink),
        .com        (comBus.source)
    );

    commitStage uCommit (
        .clk      (clk),
        .rst      (rst),
        .com      (comBus.sink),
        .comValid (comValid),
        .comName0 (comName0),
        .comTag0  (comTag0),
        .comName1 (comName1),
        .comTag1  (comTag1),
        .mapName  (mapName),
        .mapTag   (mapTag)
    );

endmodule

// File: src/sqnDispatch.sv
`timescale 1ns/1ns

module sqnDispatch (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [robPkg::WIDTH-1:0]   dispValid,
    input  logic [robPkg::NAME_W-1:0]  dispName0,
    input  logic [robPkg::TAG_W-1:0]   dispTag0,
    input  logic [robPkg::NAME_W-1:0]  dispName1,
    input  logic [robPkg::TAG_W-1:0]   dispTag1,
    input  logic                       flushValid,
    input  logic [robPkg::SQN_W-1:0]   flushSqn,
    output logic [robPkg::WIDTH-1:0]   dispAccept,
    output logic [robPkg::CNT_W-1:0]   dispCredits,
    dispatchIf.source                  rob
);

    logic [robPkg::CNT_W-1:0] credits;
    logic [robPkg::SQN_W-1:0] nextSqn;
    robPkg::flushPhase phase;

    // pending lanes thrown away by the last flush
    logic [1:0] discardCnt;
    logic [robPkg::CNT_W-1:0] acceptCnt;
    logic [robPkg::CNT_W-1:0] refund;

    // lane 1 needs lane 0 and a second credit
    always_comb begin
        dispAccept = '0;
        if (!flushValid && credits != '0) begin
            dispAccept[0] = dispValid[0];
            dispAccept[1] = dispValid[0] && dispValid[1] && (credits >= 2);
        end
    end

    always_comb begin
        acceptCnt = '0;
        if (dispAccept[0]) begin
            acceptCnt = acceptCnt + 1'b1;
        end
        if (dispAccept[1]) begin
            acceptCnt = acceptCnt + 1'b1;
        end
        // discarded lanes come back the cycle after the flush
        refund = '0;
        if (phase == robPkg::FLUSH_RECOVER) begin
            refund[1:0] = discardCnt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= robPkg::CREDIT_MAX;
            nextSqn <= '0;
            phase <= robPkg::FLUSH_IDLE;
            discardCnt <= '0;
            rob.opValid <= '0;
        end else begin
            credits <= credits + rob.creditReturn + refund - acceptCnt;
            if (flushValid) begin
                // resume numbering right after the flush point
                nextSqn <= flushSqn + 1'b1;
                discardCnt <= {1'b0, rob.opValid[0]} + {1'b0, rob.opValid[1]};
                rob.opValid <= '0;
                phase <= robPkg::FLUSH_RECOVER;
            end else begin
                nextSqn <= nextSqn + acceptCnt;
                rob.opValid <= dispAccept;
                phase <= robPkg::FLUSH_IDLE;
            end
        end
    end

    // lane payload, qualified by opValid
    always_ff @(posedge clk) begin
        rob.opSqn[0] <= nextSqn;
        rob.opSqn[1] <= nextSqn + 1'b1;
        rob.opTag[0] <= dispTag0;
        rob.opTag[1] <= dispTag1;
        rob.opName[0] <= dispName0;
        rob.opName[1] <= dispName1;
    end

    assign dispCredits = credits;

endmodule
